// File: rtl/core_ctrl_config.svh
/* width settings for the core controller, shared by RTL and testbench
   cause width must be one more than the irq id width (interrupt flag on top) */
`ifndef CORE_CTRL_CONFIG_SVH
`define CORE_CTRL_CONFIG_SVH

//////////////////////////////////////////////////
// data path widths
//////////////////////////////////////////////////

// one machine word, width of mtval and the lsu address
`define CC_XLEN 32

// compressed (RVC) instruction half
`define CC_CINSN_W 16

//////////////////////////////////////////////////
// trap and interrupt widths
//////////////////////////////////////////////////

// id of a fast/external interrupt line
`define CC_IRQ_ID_W 5

// mcause code as seen by the CSR file
`define CC_CAUSE_W 6

`endif

// File: rtl/core_ctrl_pkg.sv
/* shared enums and packed structs of the core controller
   encodings of exc_cause_e follow the RISC-V privileged mcause values */
`default_nettype none
`include "core_ctrl_config.svh"

package core_ctrl_pkg;

  // fetch address source, picked by the IF stage on pc_set
  typedef enum logic [1:0] {
    PC_BOOT = 2'b00,
    PC_JUMP = 2'b01,
    PC_EXC  = 2'b10,
    PC_ERET = 2'b11
  } pc_sel_e;

  // vector offset inside the trap table
  typedef enum logic {
    EXC_PC_EXC = 1'b0,
    EXC_PC_IRQ = 1'b1
  } exc_pc_sel_e;

  // synchronous causes; interrupts use {1'b1, irq_id}
  typedef enum logic [`CC_CAUSE_W-1:0] {
    EXC_CAUSE_INSN_ACCESS_FAULT  = 6'h01,
    EXC_CAUSE_ILLEGAL_INSN       = 6'h02,
    EXC_CAUSE_BREAKPOINT         = 6'h03,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'h05,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'h07,
    EXC_CAUSE_ECALL_MMODE        = 6'h0B
  } exc_cause_e;

  // decoder flags for the instruction in ID
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebreak;
    logic csr_status;
  } dec_flags_t;

  // IF-ID pipeline register contents
  typedef struct packed {
    logic                   valid;
    logic [`CC_XLEN-1:0]    instr;
    logic [`CC_CINSN_W-1:0] instr_c;
    logic                   is_compressed;
  } id_instr_t;

  // multicycle stall sources
  typedef struct packed {
    logic lsu;
    logic multdiv;
    logic jump;
    logic branch;
  } stall_t;

  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
  } pc_ctrl_t;

  // CSR file strobes
  typedef struct packed {
    logic save_if;
    logic save_id;
    logic restore_mret;
    logic save_cause;
  } csr_ctrl_t;

  // interrupt controller view
  typedef struct packed {
    logic                     irq_req;
    logic [`CC_IRQ_ID_W-1:0]  irq_id;
    logic                     m_ie;
  } irq_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/ctrl_fsm.sv
/* main control FSM, no debug support; ebreak always traps
   decoder flags and id_instr must stay stable while in FLUSH (ID is halted) */
`timescale 1ns/1ps
`default_nettype none
`include "core_ctrl_config.svh"

module ctrl_fsm (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       fetch_enable_i,
  input  wire logic                       irq_i,
  input  wire core_ctrl_pkg::irq_ctrl_t   irq_ctrl_i,
  input  wire logic                       branch_set_i,
  input  wire logic                       jump_set_i,
  input  wire core_ctrl_pkg::dec_flags_t  dec_flags_i,
  input  wire logic                       instr_valid_i,
  input  wire core_ctrl_pkg::stall_t      stall_i,
  input  wire logic                       exc_req_i,
  input  wire logic                       exc_flush_i,
  input  wire core_ctrl_pkg::exc_cause_e  sync_cause_i,
  output logic                            err_capture_o,
  output core_ctrl_pkg::pc_ctrl_t         pc_ctrl_o,
  output core_ctrl_pkg::csr_ctrl_t        csr_ctrl_o,
  output core_ctrl_pkg::exc_cause_e       exc_cause_o,
  output logic [`CC_IRQ_ID_W-1:0]         irq_id_o,
  output logic                            instr_req_o,
  output logic                            halt_if_o,
  output logic                            id_ready_o,
  output logic                            id_valid_o,
  output logic                            instr_valid_clear_o,
  output logic                            deassert_we_o,
  output logic                            ctrl_busy_o,
  output logic                            first_fetch_o,
  output logic                            is_decoding_o,
  output logic                            irq_ack_o,
  output logic                            exc_ack_o
);

  typedef enum logic [2:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_state_e;

  ctrl_state_e state_q, state_d;

  logic stall;
  logic halt_id;
  logic irq;
  logic special_req;

  // interrupt only counts when globally enabled in M-mode
  assign irq = irq_ctrl_i.irq_req & irq_ctrl_i.m_ie;

  // anything that needs the pipeline drained first
  assign special_req = dec_flags_i.mret | dec_flags_i.wfi | dec_flags_i.csr_status | exc_req_i;

  assign irq_id_o = irq_ctrl_i.irq_id;

  //////////////////////////////////////////////////
  // next state and strobes
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    first_fetch_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id       = 1'b0;
    err_capture_o = 1'b0;
    irq_ack_o     = 1'b0;
    exc_ack_o     = 1'b0;
    pc_ctrl_o     = '{pc_set: 1'b0, pc_mux: core_ctrl_pkg::PC_BOOT,
                      exc_pc_mux: core_ctrl_pkg::EXC_PC_IRQ};
    csr_ctrl_o    = '0;
    exc_cause_o   = core_ctrl_pkg::EXC_CAUSE_INSN_ACCESS_FAULT;

    unique case (state_q)
      // hold boot address until software lets the core run
      RESET: begin
        instr_req_o      = 1'b0;
        pc_ctrl_o.pc_set = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      BOOT_SET: begin
        pc_ctrl_o.pc_set = 1'b1;
        state_d          = FIRST_FETCH;
      end

      // one cycle to let the last request settle
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id     = 1'b1;
        state_d     = SLEEP;
      end

      // wake on any pending line, even if masked
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id     = 1'b1;
        if (irq_i) begin
          state_d = FIRST_FETCH;
        end
      end

      FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        if (id_ready_o) begin
          state_d = DECODE;
        end
        // pipeline is empty here, so irq can go straight in
        if (irq) begin
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id   = 1'b1;
        end
      end

      DECODE: begin
        if (instr_valid_i) begin
          is_decoding_o = 1'b1;
          if (branch_set_i || jump_set_i) begin
            pc_ctrl_o.pc_set = 1'b1;
            pc_ctrl_o.pc_mux = core_ctrl_pkg::PC_JUMP;
          end else if (special_req) begin
            state_d       = FLUSH;
            halt_if_o     = 1'b1;
            halt_id       = 1'b1;
            err_capture_o = 1'b1;
          end
          // keep IF from refilling while irq waits on a multicycle op
          if (irq && stall) begin
            halt_if_o = 1'b1;
          end
        end
        // running instruction and its exceptions win over interrupts
        if (irq && !stall && !special_req) begin
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id   = 1'b1;
        end
      end

      IRQ_TAKEN: begin
        pc_ctrl_o.pc_set     = 1'b1;
        pc_ctrl_o.pc_mux     = core_ctrl_pkg::PC_EXC;
        pc_ctrl_o.exc_pc_mux = core_ctrl_pkg::EXC_PC_IRQ;
        csr_ctrl_o.save_if    = 1'b1;
        csr_ctrl_o.save_cause = 1'b1;
        exc_cause_o = core_ctrl_pkg::exc_cause_e'({1'b1, irq_ctrl_i.irq_id});
        irq_ack_o   = 1'b1;
        exc_ack_o   = 1'b1;
        state_d     = DECODE;
      end

      FLUSH: begin
        halt_if_o = 1'b1;
        halt_id   = 1'b1;
        state_d   = DECODE;
        if (exc_flush_i) begin
          // trap: save PC of the faulting instruction in ID
          pc_ctrl_o.pc_set      = 1'b1;
          pc_ctrl_o.pc_mux      = core_ctrl_pkg::PC_EXC;
          pc_ctrl_o.exc_pc_mux  = core_ctrl_pkg::EXC_PC_EXC;
          csr_ctrl_o.save_id    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          exc_cause_o           = sync_cause_i;
        end else if (dec_flags_i.mret) begin
          pc_ctrl_o.pc_set        = 1'b1;
          pc_ctrl_o.pc_mux        = core_ctrl_pkg::PC_ERET;
          csr_ctrl_o.restore_mret = 1'b1;
        end else if (dec_flags_i.wfi) begin
          state_d = WAIT_SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // ID stage handshake
  //////////////////////////////////////////////////

  // any multicycle source keeps the instruction in ID
  assign stall = |stall_i;
  assign id_ready_o = ~stall;

  // drop IF-ID contents once done or when flushing
  assign instr_valid_clear_o = id_ready_o | halt_id;
  assign id_valid_o          = id_ready_o & ~halt_id;

  // no register writes when idle or on an illegal encoding
  assign deassert_we_o = ~is_decoding_o | dec_flags_i.illegal;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/trap_unit.sv
/* synchronous trap cause and mtval, combinational from the ID stage flags
   LSU errors are only held for the single FLUSH cycle after capture */
`timescale 1ns/1ps
`default_nettype none
`include "core_ctrl_config.svh"

module trap_unit (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire core_ctrl_pkg::dec_flags_t  dec_flags_i,
  input  wire core_ctrl_pkg::id_instr_t   id_instr_i,
  input  wire logic [`CC_XLEN-1:0]        lsu_addr_last_i,
  input  wire logic                       load_err_i,
  input  wire logic                       store_err_i,
  input  wire logic                       err_capture_i,
  output logic                            exc_req_o,
  output logic                            exc_flush_o,
  output core_ctrl_pkg::exc_cause_e       sync_cause_o,
  output logic [`CC_XLEN-1:0]             mtval_o
);

  logic load_err_q;
  logic store_err_q;
  logic dec_exc;

  //////////////////////////////////////////////////
  // LSU error capture
  //////////////////////////////////////////////////

  // errors arrive in decode, but the trap is taken in FLUSH
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      // cleared again on the edge after capture
      load_err_q  <= err_capture_i & load_err_i;
      store_err_q <= err_capture_i & store_err_i;
    end
  end

  //////////////////////////////////////////////////
  // request summary
  //////////////////////////////////////////////////

  // exceptions raised by the decoder itself
  assign dec_exc = dec_flags_i.illegal | dec_flags_i.ecall | dec_flags_i.ebreak;

  // raw errors for the decode-time request
  assign exc_req_o = dec_exc | load_err_i | store_err_i;

  // latched errors once the FSM sits in FLUSH
  assign exc_flush_o = dec_exc | load_err_q | store_err_q;

  //////////////////////////////////////////////////
  // cause priority and trap value
  //////////////////////////////////////////////////

  always_comb begin
    sync_cause_o = core_ctrl_pkg::EXC_CAUSE_INSN_ACCESS_FAULT;
    mtval_o      = '0;

    // illegal > ecall > ebreak > store fault > load fault
    if (dec_flags_i.illegal) begin
      sync_cause_o = core_ctrl_pkg::EXC_CAUSE_ILLEGAL_INSN;
      if (id_instr_i.is_compressed) begin
        // only the 16-bit half is the real encoding
        mtval_o = {{(`CC_XLEN-`CC_CINSN_W){1'b0}}, id_instr_i.instr_c};
      end else begin
        mtval_o = id_instr_i.instr;
      end
    end else if (dec_flags_i.ecall) begin
      sync_cause_o = core_ctrl_pkg::EXC_CAUSE_ECALL_MMODE;
    end else if (dec_flags_i.ebreak) begin
      sync_cause_o = core_ctrl_pkg::EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      sync_cause_o = core_ctrl_pkg::EXC_CAUSE_STORE_ACCESS_FAULT;
      mtval_o      = lsu_addr_last_i;
    end else if (load_err_q) begin
      sync_cause_o = core_ctrl_pkg::EXC_CAUSE_LOAD_ACCESS_FAULT;
      mtval_o      = lsu_addr_last_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/core_ctrl.sv
/* controller top, FSM plus trap unit
   csr_mtval_o is valid only while csr_ctrl_o.save_cause is high */
`timescale 1ns/1ps
`default_nettype none
`include "core_ctrl_config.svh"

module core_ctrl (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       fetch_enable_i,
  input  wire logic                       irq_i,
  input  wire core_ctrl_pkg::irq_ctrl_t   irq_ctrl_i,
  input  wire logic                       branch_set_i,
  input  wire logic                       jump_set_i,
  input  wire core_ctrl_pkg::dec_flags_t  dec_flags_i,
  input  wire core_ctrl_pkg::id_instr_t   id_instr_i,
  input  wire core_ctrl_pkg::stall_t      stall_i,
  input  wire logic [`CC_XLEN-1:0]        lsu_addr_last_i,
  input  wire logic                       load_err_i,
  input  wire logic                       store_err_i,
  output core_ctrl_pkg::pc_ctrl_t         pc_ctrl_o,
  output core_ctrl_pkg::csr_ctrl_t        csr_ctrl_o,
  output core_ctrl_pkg::exc_cause_e       exc_cause_o,
  output logic [`CC_XLEN-1:0]             csr_mtval_o,
  output logic [`CC_IRQ_ID_W-1:0]         irq_id_o,
  output logic                            instr_req_o,
  output logic                            halt_if_o,
  output logic                            id_ready_o,
  output logic                            id_valid_o,
  output logic                            instr_valid_clear_o,
  output logic                            deassert_we_o,
  output logic                            ctrl_busy_o,
  output logic                            first_fetch_o,
  output logic                            is_decoding_o,
  output logic                            irq_ack_o,
  output logic                            exc_ack_o
);

  // trap unit to FSM
  logic                      exc_req;
  logic                      exc_flush;
  core_ctrl_pkg::exc_cause_e sync_cause;
  // FSM to trap unit, marks the decode cycle entering FLUSH
  logic                      err_capture;

  ctrl_fsm u_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_enable_i      (fetch_enable_i),
    .irq_i               (irq_i),
    .irq_ctrl_i          (irq_ctrl_i),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .dec_flags_i         (dec_flags_i),
    .instr_valid_i       (id_instr_i.valid),
    .stall_i             (stall_i),
    .exc_req_i           (exc_req),
    .exc_flush_i         (exc_flush),
    .sync_cause_i        (sync_cause),
    .err_capture_o       (err_capture),
    .pc_ctrl_o           (pc_ctrl_o),
    .csr_ctrl_o          (csr_ctrl_o),
    .exc_cause_o         (exc_cause_o),
    .irq_id_o            (irq_id_o),
    .instr_req_o         (instr_req_o),
    .halt_if_o           (halt_if_o),
    .id_ready_o          (id_ready_o),
    .id_valid_o          (id_valid_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .deassert_we_o       (deassert_we_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .first_fetch_o       (first_fetch_o),
    .is_decoding_o       (is_decoding_o),
    .irq_ack_o           (irq_ack_o),
    .exc_ack_o           (exc_ack_o)
  );

  trap_unit u_trap (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .dec_flags_i     (dec_flags_i),
    .id_instr_i      (id_instr_i),
    .lsu_addr_last_i (lsu_addr_last_i),
    .load_err_i      (load_err_i),
    .store_err_i     (store_err_i),
    .err_capture_i   (err_capture),
    .exc_req_o       (exc_req),
    .exc_flush_o     (exc_flush),
    .sync_cause_o    (sync_cause),
    .mtval_o         (csr_mtval_o)
  );

endmodule

`default_nettype wire

// File: dv/core_ctrl_assert.sv
/* protocol properties on the controller ports, bound into core_ctrl
   all of them are disabled while rst_ni is low */
`timescale 1ns/1ps
`default_nettype none

module core_ctrl_assert (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire core_ctrl_pkg::pc_ctrl_t  pc_ctrl_o,
  input  wire core_ctrl_pkg::stall_t    stall_i,
  input  wire logic                     id_ready_o,
  input  wire logic                     instr_req_o,
  input  wire logic                     ctrl_busy_o,
  input  wire logic                     irq_ack_o,
  input  wire logic                     exc_ack_o
);

  // number of property failures seen so far
  int unsigned fail_count;

  //////////////////////////////////////////////////
  // interrupt entry
  //////////////////////////////////////////////////

  // taking an irq is a trap, so it must redirect fetch too
  irq_ack_is_trap: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> (exc_ack_o && pc_ctrl_o.pc_set)
  ) else begin
    fail_count++;
    $error("irq_ack without exc_ack and pc_set");
  end

  //////////////////////////////////////////////////
  // ID stage and fetch
  //////////////////////////////////////////////////

  // any multicycle source holds the instruction in ID
  stall_blocks_ready: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (|stall_i) |-> !id_ready_o
  ) else begin
    fail_count++;
    $error("id_ready high during a stall");
  end

  // sleeping core issues no fetches
  idle_no_fetch: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !ctrl_busy_o |-> !instr_req_o
  ) else begin
    fail_count++;
    $error("instr_req high while ctrl_busy is low");
  end

endmodule

`default_nettype wire

// File: dv/core_ctrl_tb.sv
/* runs the scenarios in dv/core_ctrl_stimulus.txt, relative to the project root
   inputs change 5 ns after the rising edge, outputs are sampled on the falling edge */
`timescale 1ns/1ps
`default_nettype none
`include "core_ctrl_config.svh"

module core_ctrl_tb;

  localparam int TIMEOUT      = 50;
  localparam int SEL_DECODING = 0;
  localparam int SEL_FIRST    = 1;
  localparam int SEL_IRQ_ACK  = 2;
  localparam int SEL_BUSY     = 3;

  logic                      clk;
  logic                      rst_n;
  logic                      fetch_enable;
  logic                      irq_wake;
  core_ctrl_pkg::irq_ctrl_t  irq_ctrl;
  logic                      branch_set;
  logic                      jump_set;
  core_ctrl_pkg::dec_flags_t dec_flags;
  core_ctrl_pkg::id_instr_t  id_instr;
  core_ctrl_pkg::stall_t     stall;
  logic [`CC_XLEN-1:0]       lsu_addr;
  logic                      load_err;
  logic                      store_err;

  core_ctrl_pkg::pc_ctrl_t   pc_ctrl;
  core_ctrl_pkg::csr_ctrl_t  csr_ctrl;
  core_ctrl_pkg::exc_cause_e exc_cause;
  logic [`CC_XLEN-1:0]       mtval;
  logic [`CC_IRQ_ID_W-1:0]   irq_id;
  logic instr_req, halt_if, id_ready, id_valid, valid_clear, deassert_we;
  logic ctrl_busy, first_fetch, is_decoding, irq_ack, exc_ack;

  // one stimulus line
  logic [8*24-1:0]          test_name;
  logic [8*200-1:0]         line_buf;
  int                       kind;
  logic [5:0]               flags_f;
  logic                     cmp_f;
  logic [`CC_XLEN-1:0]      instr_f;
  logic [`CC_CINSN_W-1:0]   instr_c_f;
  logic [3:0]               bits_f;
  logic [`CC_XLEN-1:0]      addr_f;
  logic [`CC_IRQ_ID_W-1:0]  irq_id_f;
  logic [`CC_CAUSE_W-1:0]   exp_cause;
  int                       exp_redir;
  logic [`CC_XLEN-1:0]      exp_mtval;

  always #50 clk = ~clk;

  core_ctrl dut (
    .clk_i (clk), .rst_ni (rst_n), .fetch_enable_i (fetch_enable), .irq_i (irq_wake),
    .irq_ctrl_i (irq_ctrl), .branch_set_i (branch_set), .jump_set_i (jump_set),
    .dec_flags_i (dec_flags), .id_instr_i (id_instr), .stall_i (stall),
    .lsu_addr_last_i (lsu_addr), .load_err_i (load_err), .store_err_i (store_err),
    .pc_ctrl_o (pc_ctrl), .csr_ctrl_o (csr_ctrl), .exc_cause_o (exc_cause),
    .csr_mtval_o (mtval), .irq_id_o (irq_id), .instr_req_o (instr_req),
    .halt_if_o (halt_if), .id_ready_o (id_ready), .id_valid_o (id_valid),
    .instr_valid_clear_o (valid_clear), .deassert_we_o (deassert_we),
    .ctrl_busy_o (ctrl_busy), .first_fetch_o (first_fetch), .is_decoding_o (is_decoding),
    .irq_ack_o (irq_ack), .exc_ack_o (exc_ack)
  );

  bind core_ctrl core_ctrl_assert u_assert (
    .clk_i (clk_i), .rst_ni (rst_ni), .pc_ctrl_o (pc_ctrl_o), .stall_i (stall_i),
    .id_ready_o (id_ready_o), .instr_req_o (instr_req_o), .ctrl_busy_o (ctrl_busy_o),
    .irq_ack_o (irq_ack_o), .exc_ack_o (exc_ack_o)
  );

  //////////////////////////////////////////////////
  // checks and waits
  //////////////////////////////////////////////////

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) else begin
      $display("Fail %0s %0s: expected %h, actual %h", test_name, what, exp, act);
      $display("Test failed");
      $fatal(1, "%0s mismatch", what);
    end
  endtask

  function automatic logic pick(input int which);
    logic v;
    case (which)
      SEL_DECODING: v = is_decoding;
      SEL_FIRST:    v = first_fetch;
      SEL_IRQ_ACK:  v = irq_ack;
      default:      v = ctrl_busy;
    endcase
    return v;
  endfunction

  // returns on the falling edge where the output reaches the level
  task automatic wait_for(input int which, input logic level, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (pick(which) != level) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout: %0s never came in %0s", what, test_name);
        $display("Test failed");
        $fatal(1, "wait timeout");
      end
      @(negedge clk);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  //////////////////////////////////////////////////
  // input drivers
  //////////////////////////////////////////////////

  // idle: a valid nop sits in ID
  task automatic clear_inputs();
    irq_ctrl               = '0;
    branch_set             = 1'b0;
    jump_set               = 1'b0;
    dec_flags              = '0;
    stall                  = '0;
    lsu_addr               = '0;
    load_err               = 1'b0;
    store_err              = 1'b0;
    id_instr.valid         = 1'b1;
    id_instr.instr         = 32'h0000_0013;
    id_instr.instr_c       = '0;
    id_instr.is_compressed = 1'b0;
  endtask

  task automatic apply_instr();
    dec_flags              = core_ctrl_pkg::dec_flags_t'(flags_f);
    id_instr.instr         = instr_f;
    id_instr.instr_c       = instr_c_f;
    id_instr.is_compressed = cmp_f;
    lsu_addr               = addr_f;
    store_err              = bits_f[1];
    load_err               = bits_f[0];
  endtask

  task automatic raise_irq(input logic enable);
    irq_ctrl.irq_req = 1'b1;
    irq_ctrl.irq_id  = irq_id_f;
    irq_ctrl.m_ie    = enable;
  endtask

  // redirect code of the stimulus file to the fetch selector
  function automatic core_ctrl_pkg::pc_sel_e redir_sel(input int code);
    case (code)
      1:       return core_ctrl_pkg::PC_JUMP;
      2:       return core_ctrl_pkg::PC_EXC;
      3:       return core_ctrl_pkg::PC_ERET;
      default: return core_ctrl_pkg::PC_BOOT;
    endcase
  endfunction

  task automatic check_redirect();
    check_eq("pc_set", 32'(exp_redir != 0), 32'(pc_ctrl.pc_set));
    if (exp_redir != 0) begin
      check_eq("pc_mux", 32'(redir_sel(exp_redir)), 32'(pc_ctrl.pc_mux));
    end
  endtask

  //////////////////////////////////////////////////
  // scenarios
  //////////////////////////////////////////////////

  task automatic boot_sequence();
    test_name       = '0;
    test_name[31:0] = "boot";
    repeat (8) @(posedge clk);
    #5;
    rst_n = 1'b1;
    @(negedge clk);
    check_eq("pc_set", 32'(1), 32'(pc_ctrl.pc_set));
    check_eq("pc_mux", 32'(core_ctrl_pkg::PC_BOOT), 32'(pc_ctrl.pc_mux));
    check_eq("instr_req", 32'(0), 32'(instr_req));
    check_eq("ctrl_busy", 32'(1), 32'(ctrl_busy));
    next_cycle();
    fetch_enable = 1'b1;
    wait_for(SEL_FIRST, 1'b1, "first_fetch");
  endtask

  // special request in decode, then the trap or return in FLUSH
  task automatic decode_special();
    wait_for(SEL_DECODING, 1'b1, "is_decoding");
    next_cycle();
    apply_instr();
    @(negedge clk);
    check_eq("halt_if", 32'(1), 32'(halt_if));
    check_eq("deassert_we", 32'(flags_f[5]), 32'(deassert_we));
    // ID is halted for the flush, its contents are dropped but never handed on
    check_eq("id_valid", 32'(0), 32'(id_valid));
    check_eq("instr_valid_clear", 32'(1), 32'(valid_clear));
    @(negedge clk);
    check_redirect();
    check_eq("save_cause", 32'(exp_redir == 2), 32'(csr_ctrl.save_cause));
    check_eq("restore_mret", 32'(exp_redir == 3), 32'(csr_ctrl.restore_mret));
    if (exp_redir == 2) begin
      check_eq("exc_pc_mux", 32'(core_ctrl_pkg::EXC_PC_EXC), 32'(pc_ctrl.exc_pc_mux));
      check_eq("save_id", 32'(1), 32'(csr_ctrl.save_id));
      check_eq("exc_cause", 32'(exp_cause), 32'(exc_cause));
      check_eq("mtval", exp_mtval, mtval);
    end
    next_cycle();
    clear_inputs();
  endtask

  task automatic decode_redirect();
    wait_for(SEL_DECODING, 1'b1, "is_decoding");
    next_cycle();
    jump_set   = (kind == 1);
    branch_set = (kind == 2);
    @(negedge clk);
    check_redirect();
    // no stall and no halt, so the instruction leaves ID normally
    check_eq("id_ready", 32'(1), 32'(id_ready));
    check_eq("id_valid", 32'(1), 32'(id_valid));
    check_eq("instr_valid_clear", 32'(1), 32'(valid_clear));
    next_cycle();
    clear_inputs();
  endtask

  task automatic check_irq_taken();
    check_redirect();
    check_eq("exc_ack", 32'(1), 32'(exc_ack));
    check_eq("exc_pc_mux", 32'(core_ctrl_pkg::EXC_PC_IRQ), 32'(pc_ctrl.exc_pc_mux));
    check_eq("save_if", 32'(1), 32'(csr_ctrl.save_if));
    check_eq("save_cause", 32'(1), 32'(csr_ctrl.save_cause));
    check_eq("exc_cause", 32'(exp_cause), 32'(exc_cause));
    check_eq("irq_id", 32'(irq_id_f), 32'(irq_id));
  endtask

  task automatic take_irq();
    wait_for(SEL_DECODING, 1'b1, "is_decoding");
    next_cycle();
    raise_irq(1'b1);
    wait_for(SEL_IRQ_ACK, 1'b1, "irq_ack");
    check_irq_taken();
    next_cycle();
    clear_inputs();
  endtask

  // pending but disabled, so the core keeps running
  task automatic hold_masked_irq();
    wait_for(SEL_DECODING, 1'b1, "is_decoding");
    next_cycle();
    raise_irq(1'b0);
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      check_eq("irq_ack", 32'(0), 32'(irq_ack));
      check_redirect();
    end
    next_cycle();
    clear_inputs();
  endtask

  task automatic stall_then_irq();
    wait_for(SEL_DECODING, 1'b1, "is_decoding");
    next_cycle();
    stall = core_ctrl_pkg::stall_t'(bits_f);
    raise_irq(1'b1);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_eq("id_ready", 32'(0), 32'(id_ready));
      check_eq("irq_ack", 32'(0), 32'(irq_ack));
      check_eq("halt_if", 32'(1), 32'(halt_if));
      // the stalled instruction stays in ID
      check_eq("id_valid", 32'(0), 32'(id_valid));
      check_eq("instr_valid_clear", 32'(0), 32'(valid_clear));
    end
    next_cycle();
    stall = '0;
    wait_for(SEL_IRQ_ACK, 1'b1, "irq_ack after stall");
    check_irq_taken();
    next_cycle();
    clear_inputs();
  endtask

  // wfi holds through FLUSH, then the core idles until the wake line
  task automatic sleep_and_wake();
    wait_for(SEL_DECODING, 1'b1, "is_decoding");
    next_cycle();
    apply_instr();
    wait_for(SEL_BUSY, 1'b0, "ctrl_busy low");
    check_eq("instr_req", 32'(0), 32'(instr_req));
    check_eq("halt_if", 32'(1), 32'(halt_if));
    next_cycle();
    clear_inputs();
    irq_wake = 1'b1;
    next_cycle();
    irq_wake = 1'b0;
    wait_for(SEL_BUSY, 1'b1, "ctrl_busy high");
  endtask

  task automatic play_scenario();
    case (kind)
      0:       decode_special();
      1, 2:    decode_redirect();
      3:       take_irq();
      4:       hold_masked_irq();
      5:       stall_then_irq();
      6:       sleep_and_wake();
      default: begin
        $display("Unknown scenario kind %0d in %0s", kind, test_name);
        $display("Test failed");
        $fatal(1, "bad stimulus");
      end
    endcase
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int   fd;
    int   got;
    logic done;
    clk          = 1'b0;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    irq_wake     = 1'b0;
    clear_inputs();
    boot_sequence();
    fd = $fopen("dv/core_ctrl_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open dv/core_ctrl_stimulus.txt");
      $display("Test failed");
      $fatal(1, "no stimulus");
    end
    done = 1'b0;
    while (!done) begin
      got = $fscanf(fd, "%s", test_name);
      if (got != 1) begin
        done = 1'b1;
      end else if (test_name[7:0] == "#") begin
        // comment line
        void'($fgets(line_buf, fd));
      end else begin
        got = $fscanf(fd, "%d %b %b %h %h %b %h %h %h %d %h", kind, flags_f, cmp_f,
                      instr_f, instr_c_f, bits_f, addr_f, irq_id_f, exp_cause,
                      exp_redir, exp_mtval);
        if (got != 11) begin
          $display("Malformed stimulus line for %0s", test_name);
          $display("Test failed");
          $fatal(1, "bad stimulus");
        end else begin
          play_scenario();
        end
      end
    end
    $fclose(fd);
    if (dut.u_assert.fail_count != 0) begin
      $display("Protocol assertions failed %0d times", dut.u_assert.fail_count);
      $display("Test failed");
      $fatal(1, "protocol assertion");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: dv/core_ctrl_stimulus.txt
# name kind flags(ill ecall mret wfi ebreak csr) cmp instr instr_c bits lsu_addr irq_id cause redir mtval
# kind 0 flush 1 jump 2 branch 3 irq 4 masked 5 stalled 6 wfi, bits {store,load} or stall, redir 0 none 1 jump 2 exc 3 mret
illegal_word      0 100000 0 deadbeef 0000 0000 00000000 00 02 2 deadbeef
illegal_rvc       0 100000 1 12345678 c0de 0000 00000000 00 02 2 0000c0de
ecall             0 010000 0 00000073 0000 0000 00000000 00 0b 2 00000000
ebreak            0 000010 0 00100073 0000 0000 00000000 00 03 2 00000000
illegal_and_ecall 0 110000 0 ffffffff 0000 0000 00000000 00 02 2 ffffffff
ecall_and_ebreak  0 010010 0 00000073 0000 0000 00000000 00 0b 2 00000000
ebreak_and_store  0 000010 0 00100073 0000 0010 80001000 00 03 2 00000000
load_fault        0 000000 0 0000a503 0000 0001 0000a5a4 00 05 2 0000a5a4
store_fault       0 000000 0 00a5a023 0000 0010 20000010 00 07 2 20000010
store_and_load    0 000000 0 00a5a023 0000 0011 40000008 00 07 2 40000008
illegal_and_fault 0 100000 0 0badc0de 0000 0011 40000000 00 02 2 0badc0de
rvc_load_fault    0 000000 1 00000000 4188 0001 00001ffc 00 05 2 00001ffc
mret              0 001000 0 30200073 0000 0000 00000000 00 01 3 00000000
csr_status        0 000001 0 30001073 0000 0000 00000000 00 01 0 00000000
jump              1 000000 0 0080006f 0000 0000 00000000 00 01 1 00000000
branch            2 000000 0 00b50463 0000 0000 00000000 00 01 1 00000000
irq_taken         3 000000 0 00000013 0000 0000 00000000 0b 2b 2 00000000
irq_masked        4 000000 0 00000013 0000 0000 00000000 07 01 0 00000000
irq_multdiv_stall 5 000000 0 00000013 0000 0100 00000000 11 31 2 00000000
irq_lsu_stall     5 000000 0 00000013 0000 1000 00000000 1f 3f 2 00000000
wfi_sleep         6 000100 0 10500073 0000 0000 00000000 00 01 0 00000000
illegal_after_wfi 0 100000 0 00000000 0000 0000 00000000 00 02 2 00000000
irq_after_wfi     3 000000 0 00000013 0000 0000 00000000 03 23 2 00000000
store_after_irq   0 000000 0 00112023 0000 0010 fffffff0 00 07 2 fffffff0

// File: core_ctrl.f
+incdir+rtl
rtl/core_ctrl_pkg.sv
rtl/ctrl_fsm.sv
rtl/trap_unit.sv
rtl/core_ctrl.sv
dv/core_ctrl_assert.sv
dv/core_ctrl_tb.sv

// File: Makefile
# Verilator build and run of the core controller testbench
# the simulation exits non-zero on any failed check

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := core_ctrl_tb
FILELIST  := core_ctrl.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
